// File: all.f
logic/pitaya_pkg.sv
logic/sys_bus_decoder.sv
logic/adc_frontend.sv
logic/analog_regs.sv
logic/housekeeping_regs.sv
logic/dac_mixer.sv
logic/dac_backend.sv
logic/pitaya_top.sv
bench/pitaya_checker.sv
bench/pitaya_tb.sv

// File: bench/pitaya_checker.sv
/*
 * Protocol assertions for the system bus and the DAC interleave.
 * Bound into pitaya_top; the testbench reads fail_count at the end.
 */
`timescale 1ns/1ps
`default_nettype none

module pitaya_checker (
  input logic                                                     adc_clk,
  input logic                                                     arst_n_i,
  input logic                                                     wen_i,
  input logic                                                     ren_i,
  input logic [pitaya_pkg::REGION_MSB-pitaya_pkg::REGION_LSB:0]   region_i,
  input logic                                                     ack_i,
  input logic                                                     err_i,
  input logic                                                     dac_sel_i,
  input logic                                                     dac_rst_i
);

  int unsigned fail_count = 0;                  // read back by the testbench

  logic region_unmapped;                        // held address points at region 2..7

  assign region_unmapped = (region_i != pitaya_pkg::REGION_HK) &&
                           (region_i != pitaya_pkg::REGION_ANALOG);

  // ------------------------------
  // system bus, one ack exactly one cycle after each strobe
  ack_after_strobe: assert property (
    @(posedge adc_clk) disable iff (!arst_n_i) (wen_i || ren_i) |=> ack_i
  ) else begin
    $error("bus strobe not acked in the next cycle");
    fail_count++;
  end

  ack_needs_strobe: assert property (
    @(posedge adc_clk) disable iff (!arst_n_i) ack_i |-> $past(wen_i || ren_i)
  ) else begin
    $error("ack without a strobe one cycle before");
    fail_count++;
  end

  err_with_ack: assert property (
    @(posedge adc_clk) disable iff (!arst_n_i) err_i |-> (ack_i && region_unmapped)
  ) else begin
    $error("err raised without ack or for a mapped region");
    fail_count++;
  end

  // ------------------------------
  // DAC channel select
  sel_toggles: assert property (
    @(posedge adc_clk) disable iff (!arst_n_i) !dac_rst_i |=> (dac_sel_i != $past(dac_sel_i))
  ) else begin
    $error("dac_sel_o did not toggle");
    fail_count++;
  end

endmodule

bind pitaya_top pitaya_checker i_checker (
  .adc_clk   (adc_clk),
  .arst_n_i  (arst_n_i),
  .wen_i     (sys_wen_i),
  .ren_i     (sys_ren_i),
  .region_i  (sys_addr_i[pitaya_pkg::REGION_MSB:pitaya_pkg::REGION_LSB]),
  .ack_i     (sys_ack_o),
  .err_i     (sys_err_o),
  .dac_sel_i (dac_sel_o),
  .dac_rst_i (dac_rst_o)
);

`default_nettype wire

// File: bench/pitaya_tb.sv
/*
 * Testbench for the analog front end. Builds a table of bus accesses,
 * ADC samples and digital inputs, applies it row by row and checks read
 * data, err, led_o and the interleaved DAC words against a small model.
 */
`timescale 1ns/1ps
`default_nettype none

module pitaya_tb;

  localparam int unsigned SW       = pitaya_pkg::SAMPLE_W;
  localparam logic [31:0] BOARD_ID = 32'h5250_0001;
  localparam int unsigned SETTLE   = 4;         // idle cycles before each row's action
  localparam int unsigned ACK_WAIT = 4;         // bus timeout per access
  localparam int          POS_LIM  = 2**(SW-1) - 1;
  localparam int          NEG_LIM  = -(2**(SW-1));

  localparam logic [1:0] OP_WR  = 2'd0;
  localparam logic [1:0] OP_RD  = 2'd1;
  localparam logic [1:0] OP_DAC = 2'd2;         // settle, then check both DAC channels
  localparam logic [1:0] OP_LED = 2'd3;

  typedef struct packed {
    logic [1:0]    op;
    logic [31:0]   addr;
    logic [31:0]   wdata;
    logic [SW-1:0] adc_a;                       // raw codes held during the row
    logic [SW-1:0] adc_b;
    logic [7:0]    din;
    logic [31:0]   exp_a;                       // rdata, led value or DAC A code
    logic [SW-1:0] exp_b;                       // DAC B code
    logic          exp_err;
  } row_t;

  logic          adc_clk;
  logic          arst_n;
  logic [SW-1:0] adc_dat_a, adc_dat_b;
  logic [7:0]    exp_p;
  logic [31:0]   sys_addr, sys_wdata, sys_rdata;
  logic          sys_wen, sys_ren, sys_ack, sys_err;
  logic [SW-1:0] dac_dat;
  logic          dac_wrt, dac_sel, dac_rst;
  logic [7:0]    led;

  row_t          rows[$];
  int            err_count   = 0;
  int            check_count = 0;
  int            cycle_count = 0;
  int            cycle_limit = 0;               // set once the table is built

  // reference model state while the table is built
  logic [SW-1:0] cur_a, cur_b;
  logic [7:0]    cur_din;
  logic [SW-1:0] ref_offs_a, ref_offs_b;
  logic          ref_loop_a, ref_loop_b;

  pitaya_top #(.BOARD_ID(BOARD_ID)) i_pitaya_top (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .exp_p_i     (exp_p),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .dac_dat_o   (dac_dat),
    .dac_wrt_o   (dac_wrt),
    .dac_sel_o   (dac_sel),
    .dac_rst_o   (dac_rst),
    .led_o       (led)
  );

  always #4 adc_clk = ~adc_clk;                 // 8 ns period

  always @(posedge adc_clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("run stopped, the test did not end within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // reference model
  function automatic logic [SW-1:0] swap_code(input logic [SW-1:0] v);
    return v ^ {1'b0, {(SW-1){1'b1}}};          // msb kept, low bits inverted
  endfunction

  function automatic logic [SW-1:0] clamped_sum(input logic [SW-1:0] offs,
                                                input logic [SW-1:0] adc, input logic loop);
    int o;
    int a;
    int s;
    o = $signed(offs);
    a = $signed(adc);
    s = loop ? o + a : o;
    if (s > POS_LIM)
      s = POS_LIM;
    else if (s < NEG_LIM)
      s = NEG_LIM;
    return s[SW-1:0];
  endfunction

  function automatic logic [31:0] addr_of(input int region, input logic [19:0] offs);
    return {9'd0, region[2:0], offs};           // 1 MB per region
  endfunction

  // ------------------------------
  // table
  task automatic add_row(input logic [1:0] op, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [31:0] exp_a, input logic [SW-1:0] exp_b, input logic err);
    row_t r;
    r.op      = op;
    r.addr    = addr;
    r.wdata   = wdata;
    r.adc_a   = cur_a;
    r.adc_b   = cur_b;
    r.din     = cur_din;
    r.exp_a   = exp_a;
    r.exp_b   = exp_b;
    r.exp_err = err;
    rows.push_back(r);
  endtask

  task automatic queue_write(input logic [31:0] addr, input logic [31:0] data);
    add_row(OP_WR, addr, data, '0, '0, 1'b0);
  endtask

  task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp, input logic err);
    add_row(OP_RD, addr, '0, exp, '0, err);
  endtask

  task automatic expect_dac();
    add_row(OP_DAC, '0, '0, swap_code(clamped_sum(ref_offs_a, swap_code(cur_a), ref_loop_a)),
            swap_code(clamped_sum(ref_offs_b, swap_code(cur_b), ref_loop_b)), 1'b0);
  endtask

  task automatic build_table();
    cur_a = '0;
    cur_b = '0;
    cur_din = '0;
    expect_read(addr_of(0, pitaya_pkg::HK_ID), BOARD_ID, 1'b0);
    queue_write(addr_of(0, pitaya_pkg::HK_LED), 32'h0000_00A5);
    add_row(OP_LED, '0, '0, 32'h0000_00A5, '0, 1'b0);
    expect_read(addr_of(0, pitaya_pkg::HK_LED), 32'h0000_00A5, 1'b0);
    for (int g = 2; g < 8; g++)
      expect_read(addr_of(g, 20'h04), '0, 1'b1);          // unmapped regions
    add_row(OP_WR, addr_of(5, 20'h00), 32'hDEAD_BEEF, '0, '0, 1'b1);
    expect_read(addr_of(0, 20'h40), '0, 1'b0);            // unknown offsets read zero
    expect_read(addr_of(1, 20'h80), '0, 1'b0);
    cur_a = 14'h0123;                                     // ADC readback
    cur_b = 14'h3FF0;
    expect_read(addr_of(1, pitaya_pkg::AN_ADC_A), swap_code(cur_a), 1'b0);
    expect_read(addr_of(1, pitaya_pkg::AN_ADC_B), swap_code(cur_b), 1'b0);
    for (int k = 0; k < 2; k++) begin
      cur_a = SW'($urandom);
      cur_b = SW'($urandom);
      expect_read(addr_of(1, pitaya_pkg::AN_ADC_A), swap_code(cur_a), 1'b0);
      expect_read(addr_of(1, pitaya_pkg::AN_ADC_B), swap_code(cur_b), 1'b0);
    end
    ref_offs_a = 14'h0100;                                // loopback off
    ref_offs_b = 14'h3E00;
    ref_loop_a = 1'b0;
    ref_loop_b = 1'b0;
    queue_write(addr_of(1, pitaya_pkg::AN_CTRL), 32'h0);
    queue_write(addr_of(1, pitaya_pkg::AN_OFFS_A), ref_offs_a);
    queue_write(addr_of(1, pitaya_pkg::AN_OFFS_B), ref_offs_b);
    expect_read(addr_of(1, pitaya_pkg::AN_OFFS_A), ref_offs_a, 1'b0);
    expect_dac();
    ref_loop_a = 1'b1;                                    // loopback on, random samples
    ref_loop_b = 1'b1;
    queue_write(addr_of(1, pitaya_pkg::AN_CTRL), 32'h3);
    expect_read(addr_of(1, pitaya_pkg::AN_CTRL), 32'h3, 1'b0);
    for (int k = 0; k < 2; k++) begin
      cur_a = SW'($urandom);
      cur_b = SW'($urandom);
      expect_dac();
    end
    ref_offs_a = 14'h1F00;                                // A overflows up, B down
    ref_offs_b = 14'h2100;
    queue_write(addr_of(1, pitaya_pkg::AN_OFFS_A), ref_offs_a);
    queue_write(addr_of(1, pitaya_pkg::AN_OFFS_B), ref_offs_b);
    cur_a = 14'h1BFF;                                     // converts to +1024
    cur_b = 14'h23FF;                                     // converts to -1024
    expect_dac();
    ref_loop_b = 1'b0;
    queue_write(addr_of(1, pitaya_pkg::AN_CTRL), 32'h1);
    expect_dac();
    cur_din = 8'h5A;                                      // digital input
    expect_read(addr_of(0, pitaya_pkg::HK_DIN), 32'h5A, 1'b0);
    cur_din = 8'hC3;
    expect_read(addr_of(0, pitaya_pkg::HK_DIN), 32'hC3, 1'b0);
  endtask

  // ------------------------------
  // checks and row execution
  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic run_row(input int idx, input row_t r);
    int waited;
    int errs_before;
    errs_before = err_count;
    adc_dat_a = r.adc_a;
    adc_dat_b = r.adc_b;
    exp_p     = r.din;
    repeat (SETTLE) @(posedge adc_clk);
    #1;
    case (r.op)
      OP_WR, OP_RD: begin
        sys_addr  = r.addr;                     // held until the next row
        sys_wdata = r.wdata;
        sys_wen   = (r.op == OP_WR);
        sys_ren   = (r.op == OP_RD);
        @(posedge adc_clk);
        #1;
        sys_wen = 1'b0;
        sys_ren = 1'b0;
        waited  = 0;
        while (!sys_ack && waited < ACK_WAIT) begin
          @(posedge adc_clk);
          #1;
          waited++;
        end
        if (!sys_ack) begin
          err_count++;
          $display("row %0d: no ack came back from the bus", idx);
        end else begin
          check("sys_err_o", sys_err, r.exp_err);
          if (r.op == OP_RD)
            check("sys_rdata_o", sys_rdata, r.exp_a);
        end
      end
      OP_DAC: begin
        repeat (2) @(posedge adc_clk);          // mixer and backend latency
        repeat (2) begin
          @(posedge adc_clk);
          #1;
          check("dac_wrt_o", dac_wrt, 1'b1);
          if (dac_sel)
            check("dac_dat_o channel A", dac_dat, r.exp_a[SW-1:0]);
          else
            check("dac_dat_o channel B", dac_dat, r.exp_b);
        end
      end
      default: check("led_o", led, r.exp_a[7:0]);
    endcase
    $display("row %0d op %0d addr %h: %s", idx, r.op, r.addr,
             (err_count == errs_before) ? "ok" : "mismatch");
  endtask

  // ------------------------------
  initial begin
    int unsigned seed_val;
    seed_val  = $urandom(87);
    adc_clk   = 1'b0;
    arst_n    = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    exp_p     = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    build_table();
    cycle_limit = rows.size() * 20;
    repeat (10) @(posedge adc_clk);
    #1;
    check("dac_rst_o in reset", dac_rst, 1'b1);
    check("sys_ack_o in reset", sys_ack, 1'b0);
    check("sys_err_o in reset", sys_err, 1'b0);
    check("dac_wrt_o in reset", dac_wrt, 1'b0);
    check("dac_sel_o in reset", dac_sel, 1'b0);
    check("led_o in reset", led, 8'h00);
    arst_n = 1'b1;
    @(posedge adc_clk);
    #1;
    check("dac_rst_o after reset", dac_rst, 1'b0);
    foreach (rows[i])
      run_row(i, rows[i]);
    err_count += i_pitaya_top.i_checker.fail_count;       // assertion failures
    $display("rows %0d, checks %0d, errors %0d", rows.size(), check_count, err_count);
    if (err_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/adc_frontend.sv
/*
 * ADC input stage. Registers the raw samples of both channels and turns
 * the negative-slope offset code of the converter into two's complement.
 * One cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  logic                              adc_clk,
  input  logic                              arst_n_i,
  input  logic [pitaya_pkg::SAMPLE_W-1:0]   adc_dat_a_i,   // raw code, channel A
  input  logic [pitaya_pkg::SAMPLE_W-1:0]   adc_dat_b_i,   // raw code, channel B
  output pitaya_pkg::sample_t               adc_a_o,
  output pitaya_pkg::sample_t               adc_b_o
);

  // ------------------------------
  // input registers, converted on the way in
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= pitaya_pkg::flip_code(adc_dat_a_i);   // msb kept, rest inverted
      adc_b_o <= pitaya_pkg::flip_code(adc_dat_b_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/analog_regs.sv
/*
 * Register block of region 1. Holds the loopback control bits and the two
 * DAC offsets that feed the mixer, and reads back the latest converted ADC
 * samples. Every strobe is acked one cycle later with registered read data.
 */
`timescale 1ns/1ps
`default_nettype none

module analog_regs (
  input  logic                                adc_clk,
  input  logic                                arst_n_i,
  input  logic [pitaya_pkg::REGION_LSB-1:0]   addr_i,
  input  logic [pitaya_pkg::SYS_DW-1:0]       wdata_i,
  input  logic                                wen_i,
  input  logic                                ren_i,
  input  pitaya_pkg::sample_t                 adc_a_i,
  input  pitaya_pkg::sample_t                 adc_b_i,
  output logic [pitaya_pkg::SYS_DW-1:0]       rdata_o,
  output logic                                ack_o,
  output pitaya_pkg::sample_t                 offs_a_o,
  output pitaya_pkg::sample_t                 offs_b_o,
  output logic                                loop_a_o,
  output logic                                loop_b_o
);

  localparam int unsigned PAD_W = pitaya_pkg::SYS_DW - pitaya_pkg::SAMPLE_W;

  logic [1:0]                     ctrl_q;      // {loop_b, loop_a}
  logic [pitaya_pkg::SYS_DW-1:0]  rd_mux;

  // ------------------------------
  // write side
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q   <= 2'b00;
      offs_a_o <= '0;
      offs_b_o <= '0;
    end else if (wen_i) begin
      case (addr_i)
        pitaya_pkg::AN_CTRL:   ctrl_q   <= wdata_i[1:0];
        pitaya_pkg::AN_OFFS_A: offs_a_o <= wdata_i[pitaya_pkg::SAMPLE_W-1:0];
        pitaya_pkg::AN_OFFS_B: offs_b_o <= wdata_i[pitaya_pkg::SAMPLE_W-1:0];
        default: ;                               // read-only or unknown, ignored
      endcase
    end
  end

  assign loop_a_o = ctrl_q[0];
  assign loop_b_o = ctrl_q[1];

  // ------------------------------
  // read side, 14-bit fields sit in the low bits with the rest zero
  always_comb begin
    case (addr_i)
      pitaya_pkg::AN_CTRL:   rd_mux = {{(pitaya_pkg::SYS_DW-2){1'b0}}, ctrl_q};
      pitaya_pkg::AN_OFFS_A: rd_mux = {{PAD_W{1'b0}}, offs_a_o};
      pitaya_pkg::AN_OFFS_B: rd_mux = {{PAD_W{1'b0}}, offs_b_o};
      pitaya_pkg::AN_ADC_A:  rd_mux = {{PAD_W{1'b0}}, adc_a_i};
      pitaya_pkg::AN_ADC_B:  rd_mux = {{PAD_W{1'b0}}, adc_b_i};
      default:               rd_mux = '0;     // unknown offset reads zero
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      ack_o   <= wen_i | ren_i;               // one-cycle pulse per strobe
      rdata_o <= ren_i ? rd_mux : '0;         // no side effects on read
    end
  end

endmodule

`default_nettype wire

// File: logic/dac_backend.sv
/*
 * DAC output stage. Converts the mixer results back to the DAC offset code
 * and interleaves both channels on one data bus: channel A while dac_sel_o
 * is high, channel B while it is low. Also drives the DAC reset and write.
 */
`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  logic                              adc_clk,
  input  logic                              arst_n_i,
  input  pitaya_pkg::sample_t               mix_a_i,
  input  pitaya_pkg::sample_t               mix_b_i,
  output logic [pitaya_pkg::SAMPLE_W-1:0]   dac_dat_o,
  output logic                              dac_wrt_o,
  output logic                              dac_sel_o,
  output logic                              dac_rst_o
);

  logic sel_next;

  assign sel_next = ~dac_sel_o;               // channel shown after this edge

  // ------------------------------
  // select toggle, reset release, interleaved data
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_sel_o <= 1'b0;
      dac_rst_o <= 1'b1;                      // DAC held in reset
      dac_wrt_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= sel_next;
      dac_rst_o <= 1'b0;                      // released on first clock
      dac_wrt_o <= 1'b1;                      // a word every cycle, no back-pressure
      if (sel_next)
        dac_dat_o <= pitaya_pkg::flip_code(mix_a_i);   // A pairs with sel high
      else
        dac_dat_o <= pitaya_pkg::flip_code(mix_b_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/dac_mixer.sv
/*
 * Output mixer. Per channel it adds the programmed offset to the converted
 * ADC sample when loopback is on, clamps the 15-bit sum to the 14-bit
 * signed range and registers the result. One cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module dac_mixer (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  pitaya_pkg::sample_t   adc_a_i,
  input  pitaya_pkg::sample_t   adc_b_i,
  input  pitaya_pkg::sample_t   offs_a_i,
  input  pitaya_pkg::sample_t   offs_b_i,
  input  logic                  loop_a_i,
  input  logic                  loop_b_i,
  output pitaya_pkg::sample_t   mix_a_o,
  output pitaya_pkg::sample_t   mix_b_o
);

  localparam int unsigned MSB = pitaya_pkg::SAMPLE_W - 1;

  // sum one bit wider, top two bits differ only on overflow
  function automatic pitaya_pkg::sample_t sat_sum(
    input pitaya_pkg::sample_t offs,
    input pitaya_pkg::sample_t adc,
    input logic                loop
  );
    logic [pitaya_pkg::SAMPLE_W:0] sum;
    sum = {offs[MSB], offs} + (loop ? {adc[MSB], adc} : '0);
    case (sum[pitaya_pkg::SAMPLE_W -: 2])
      2'b01:   return pitaya_pkg::SAT_MAX;    // pos. overflow
      2'b10:   return pitaya_pkg::SAT_MIN;    // neg. overflow
      default: return sum[MSB:0];
    endcase
  endfunction

  // ------------------------------
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_sum(offs_a_i, adc_a_i, loop_a_i);
      mix_b_o <= sat_sum(offs_b_i, adc_b_i, loop_b_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/housekeeping_regs.sv
/*
 * Housekeeping registers of region 0: fixed board ID, LED register and
 * the 8-bit digital input, which passes a two-flop synchronizer before
 * it is read. Acks and read data come one cycle after the strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module housekeeping_regs #(
  parameter logic [pitaya_pkg::SYS_DW-1:0] BOARD_ID = 32'h5250_0001
) (
  input  logic                                adc_clk,
  input  logic                                arst_n_i,
  input  logic [pitaya_pkg::REGION_LSB-1:0]   addr_i,
  input  logic [pitaya_pkg::SYS_DW-1:0]       wdata_i,
  input  logic                                wen_i,
  input  logic                                ren_i,
  input  logic [pitaya_pkg::DIN_W-1:0]        exp_p_i,    // asynchronous pins
  output logic [pitaya_pkg::SYS_DW-1:0]       rdata_o,
  output logic                                ack_o,
  output logic [pitaya_pkg::LED_W-1:0]        led_o
);

  logic [pitaya_pkg::DIN_W-1:0]  din_meta;
  logic [pitaya_pkg::DIN_W-1:0]  din_sync;
  logic [pitaya_pkg::SYS_DW-1:0] rd_mux;

  // ------------------------------
  // synchronizer, LED register, bus response
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      din_meta <= '0;
      din_sync <= '0;
      led_o    <= '0;
      ack_o    <= 1'b0;
      rdata_o  <= '0;
    end else begin
      din_meta <= exp_p_i;                    // first stage, may go metastable
      din_sync <= din_meta;
      if (wen_i && (addr_i == pitaya_pkg::HK_LED))
        led_o <= wdata_i[pitaya_pkg::LED_W-1:0];
      ack_o   <= wen_i | ren_i;
      rdata_o <= ren_i ? rd_mux : '0;
    end
  end

  always_comb begin
    case (addr_i)
      pitaya_pkg::HK_ID:  rd_mux = BOARD_ID;
      pitaya_pkg::HK_LED: rd_mux = {{(pitaya_pkg::SYS_DW-pitaya_pkg::LED_W){1'b0}}, led_o};
      pitaya_pkg::HK_DIN: rd_mux = {{(pitaya_pkg::SYS_DW-pitaya_pkg::DIN_W){1'b0}}, din_sync};
      default:            rd_mux = '0;        // unknown offset
    endcase
  end

endmodule

`default_nettype wire

// File: logic/pitaya_pkg.sv
/*
 * Shared widths, bus region map, register offsets and saturation limits
 * for the two-channel analog front end. Modules refer to these by scoped
 * names, so the package must be compiled before any module that uses it.
 */
`default_nettype none

package pitaya_pkg;

  // ------------------------------
  // data path
  localparam int unsigned SAMPLE_W = 14;                // ADC and DAC sample width
  typedef logic signed [SAMPLE_W-1:0] sample_t;         // two's complement sample

  localparam sample_t SAT_MAX = 14'h1FFF;               // largest positive sample
  localparam sample_t SAT_MIN = 14'h2000;               // most negative sample

  // ------------------------------
  // system bus and region map
  localparam int unsigned SYS_AW     = 32;
  localparam int unsigned SYS_DW     = 32;
  localparam int unsigned REGION_LSB = 20;              // 1 MB per region
  localparam int unsigned REGION_MSB = 22;              // eight regions

  localparam logic [REGION_MSB-REGION_LSB:0] REGION_HK     = 3'd0;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_ANALOG = 3'd1;

  // housekeeping offsets, region 0
  localparam logic [REGION_LSB-1:0] HK_ID  = 20'h00;
  localparam logic [REGION_LSB-1:0] HK_LED = 20'h04;
  localparam logic [REGION_LSB-1:0] HK_DIN = 20'h08;

  // analog offsets, region 1
  localparam logic [REGION_LSB-1:0] AN_CTRL   = 20'h00; // bit0 loop_a, bit1 loop_b
  localparam logic [REGION_LSB-1:0] AN_OFFS_A = 20'h04;
  localparam logic [REGION_LSB-1:0] AN_OFFS_B = 20'h08;
  localparam logic [REGION_LSB-1:0] AN_ADC_A  = 20'h0C;
  localparam logic [REGION_LSB-1:0] AN_ADC_B  = 20'h10;

  localparam int unsigned LED_W = 8;
  localparam int unsigned DIN_W = 8;

  // negative-slope offset code <-> two's complement, the rule is its own inverse
  function automatic logic [SAMPLE_W-1:0] flip_code(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: logic/pitaya_top.sv
/*
 * Top level of the analog front end. Connects the bus decoder, the two
 * register regions and the ADC to DAC data path:
 * adc_frontend -> dac_mixer -> dac_backend, steered by analog_regs.
 */
`timescale 1ns/1ps
`default_nettype none

module pitaya_top #(
  parameter logic [pitaya_pkg::SYS_DW-1:0] BOARD_ID = 32'h5250_0001
) (
  input  logic                              adc_clk,
  input  logic                              arst_n_i,
  input  logic [pitaya_pkg::SAMPLE_W-1:0]   adc_dat_a_i,
  input  logic [pitaya_pkg::SAMPLE_W-1:0]   adc_dat_b_i,
  input  logic [pitaya_pkg::DIN_W-1:0]      exp_p_i,
  input  logic [pitaya_pkg::SYS_AW-1:0]     sys_addr_i,
  input  logic [pitaya_pkg::SYS_DW-1:0]     sys_wdata_i,
  input  logic                              sys_wen_i,
  input  logic                              sys_ren_i,
  output logic [pitaya_pkg::SYS_DW-1:0]     sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o,
  output logic [pitaya_pkg::SAMPLE_W-1:0]   dac_dat_o,
  output logic                              dac_wrt_o,
  output logic                              dac_sel_o,
  output logic                              dac_rst_o,
  output logic [pitaya_pkg::LED_W-1:0]      led_o
);

  // ------------------------------
  // system bus
  logic                          hk_wen, hk_ren, hk_ack;
  logic                          an_wen, an_ren, an_ack;
  logic [pitaya_pkg::SYS_DW-1:0] hk_rdata;
  logic [pitaya_pkg::SYS_DW-1:0] an_rdata;

  sys_bus_decoder i_decoder (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .an_rdata_i  (an_rdata),
    .an_ack_i    (an_ack),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .an_wen_o    (an_wen),
    .an_ren_o    (an_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  housekeeping_regs #(.BOARD_ID(BOARD_ID)) i_hk (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .addr_i   (sys_addr_i[pitaya_pkg::REGION_LSB-1:0]),   // offset within region
    .wdata_i  (sys_wdata_i),
    .wen_i    (hk_wen),
    .ren_i    (hk_ren),
    .exp_p_i  (exp_p_i),
    .rdata_o  (hk_rdata),
    .ack_o    (hk_ack),
    .led_o    (led_o)
  );

  // ------------------------------
  // data path
  pitaya_pkg::sample_t adc_a, adc_b;          // two's complement samples
  pitaya_pkg::sample_t offs_a, offs_b;
  pitaya_pkg::sample_t mix_a, mix_b;          // saturated DAC values
  logic                loop_a, loop_b;

  analog_regs i_analog_regs (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .addr_i   (sys_addr_i[pitaya_pkg::REGION_LSB-1:0]),
    .wdata_i  (sys_wdata_i),
    .wen_i    (an_wen),
    .ren_i    (an_ren),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .rdata_o  (an_rdata),
    .ack_o    (an_ack),
    .offs_a_o (offs_a),
    .offs_b_o (offs_b),
    .loop_a_o (loop_a),
    .loop_b_o (loop_b)
  );

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  dac_mixer i_mixer (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .offs_a_i (offs_a),
    .offs_b_i (offs_b),
    .loop_a_i (loop_a),
    .loop_b_i (loop_b),
    .mix_a_o  (mix_a),
    .mix_b_o  (mix_b)
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .mix_a_i   (mix_a),
    .mix_b_i   (mix_b),
    .dac_dat_o (dac_dat_o),
    .dac_wrt_o (dac_wrt_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: logic/sys_bus_decoder.sv
/*
 * System bus decoder. Splits the address space into eight 1 MB regions,
 * forwards the strobes to region 0 (housekeeping) or region 1 (analog)
 * and muxes their responses back. Regions 2 to 7 get ack with err.
 */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  logic                            adc_clk,
  input  logic                            arst_n_i,
  input  logic [pitaya_pkg::SYS_AW-1:0]   sys_addr_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  input  logic [pitaya_pkg::SYS_DW-1:0]   hk_rdata_i,
  input  logic                            hk_ack_i,
  input  logic [pitaya_pkg::SYS_DW-1:0]   an_rdata_i,
  input  logic                            an_ack_i,
  output logic                            hk_wen_o,
  output logic                            hk_ren_o,
  output logic                            an_wen_o,
  output logic                            an_ren_o,
  output logic [pitaya_pkg::SYS_DW-1:0]   sys_rdata_o,
  output logic                            sys_ack_o,
  output logic                            sys_err_o
);

  localparam int unsigned RW = pitaya_pkg::REGION_MSB - pitaya_pkg::REGION_LSB + 1;

  logic [RW-1:0] region;
  logic          sel_hk;
  logic          sel_an;
  logic          unmapped_q;                    // strobe hit region 2..7 last cycle

  // ------------------------------
  // region select, address held by master until ack
  assign region = sys_addr_i[pitaya_pkg::REGION_MSB:pitaya_pkg::REGION_LSB];
  assign sel_hk = (region == pitaya_pkg::REGION_HK);
  assign sel_an = (region == pitaya_pkg::REGION_ANALOG);

  assign hk_wen_o = sys_wen_i & sel_hk;
  assign hk_ren_o = sys_ren_i & sel_hk;
  assign an_wen_o = sys_wen_i & sel_an;
  assign an_ren_o = sys_ren_i & sel_an;

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= (sys_wen_i | sys_ren_i) & ~sel_hk & ~sel_an;
    end
  end

  // ------------------------------
  // response mux
  assign sys_ack_o = (sel_hk & hk_ack_i) | (sel_an & an_ack_i) | unmapped_q;
  assign sys_err_o = unmapped_q;              // only unmapped regions fail

  always_comb begin
    if (sel_hk) begin
      sys_rdata_o = hk_rdata_i;
    end else if (sel_an) begin
      sys_rdata_o = an_rdata_i;
    end else begin
      sys_rdata_o = '0;                       // unmapped reads return zero
    end
  end

endmodule

`default_nettype wire
